// File: rtl/dc_pkg.sv
package dc_pkg;

    parameter int WORD_W     = 16;
    parameter int ROWS       = 16;
    parameter int ROW_W      = 4;
    parameter int ADDR_W     = 16;
    parameter int TAG_W      = 12;  // addr bits 15..4
    parameter int DDR_ADDR_W = 28;

    typedef enum logic [2:0] {
        OP_ROW_READ  = 3'd0,
        OP_ROW_WRITE = 3'd1,
        OP_COL_READ  = 3'd2,
        OP_COL_WRITE = 3'd3,
        OP_FLUSH     = 3'd4
    } dc_op_t;

    typedef enum logic [2:0] {
        S_IDLE      = 3'd0,
        S_CHECK     = 3'd1,
        S_WRITEBACK = 3'd2,
        S_FILL      = 3'd3,
        S_ACCESS    = 3'd4,
        S_RESPOND   = 3'd5
    } dc_state_t;

    typedef struct packed {
        dc_op_t              op;
        logic [ADDR_W-1:0]   addr;
        logic [ROW_W-1:0]    col;   // bit position for column commands
        logic [WORD_W-1:0]   wdata;
    } dc_cmd_t;

    typedef struct packed {
        dc_op_t              op;
        logic                hit;
        logic [WORD_W-1:0]   rdata;
    } dc_rsp_t;

    typedef struct packed {
        logic                  write;
        logic [DDR_ADDR_W-1:0] addr;  // block base
    } ddr_req_t;

    typedef struct packed {
        logic [ROW_W-1:0]  idx;
        logic [WORD_W-1:0] data;
    } ddr_wr_t;

endpackage

// File: rtl/dc_cmd_queue.sv
`timescale 1ns/10ps

module dc_cmd_queue #(
    parameter int CMD_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmd_valid,
    input  dc_pkg::dc_cmd_t cmd,
    input  logic            pop,
    output logic            cmd_credit,
    output dc_pkg::dc_cmd_t head,
    output logic            head_valid
);

    localparam int PTR_W = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1;
    localparam int CNT_W = $clog2(CMD_DEPTH + 1);

    dc_pkg::dc_cmd_t mem [CMD_DEPTH];
    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [CNT_W-1:0] count;
    logic push;
    logic pop_ok;

    assign push       = cmd_valid && (count != CMD_DEPTH);  // producer credits keep this true
    assign pop_ok     = pop && head_valid;
    assign head_valid = (count != 0);
    assign head       = mem[rptr];

    always_ff @(posedge clk) begin
        if (push) mem[wptr] <= cmd;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wptr       <= '0;
            rptr       <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            cmd_credit <= pop_ok;  // one credit back per popped entry
            if (push) wptr <= (wptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : wptr + 1'b1;
            if (pop_ok) rptr <= (rptr == PTR_W'(CMD_DEPTH - 1)) ? '0 : rptr + 1'b1;
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: rtl/dc_block_array.sv
`timescale 1ns/10ps

module dc_block_array (
    input  logic                       clk,
    input  logic                       row_we,
    input  logic [dc_pkg::ROW_W-1:0]   row_idx,
    input  logic [dc_pkg::WORD_W-1:0]  row_wdata,
    input  logic                       col_we,
    input  logic [dc_pkg::ROW_W-1:0]   col_idx,
    input  logic [dc_pkg::ROWS-1:0]    col_wdata,
    output logic [dc_pkg::WORD_W-1:0]  row_rdata,
    output logic [dc_pkg::ROWS-1:0]    col_rdata
);

    logic [dc_pkg::WORD_W-1:0] mem [dc_pkg::ROWS];

    // one bit per row on a column write
    always_ff @(posedge clk) begin
        if (row_we) begin
            mem[row_idx] <= row_wdata;
        end
        if (col_we) begin
            for (int r = 0; r < dc_pkg::ROWS; r++) begin
                mem[r][col_idx] <= col_wdata[r];
            end
        end
    end

    assign row_rdata = mem[row_idx];

    always_comb begin
        for (int r = 0; r < dc_pkg::ROWS; r++) begin
            col_rdata[r] = mem[r][col_idx];  // bit r from row r
        end
    end

endmodule

// File: rtl/dc_ddr_mover.sv
`timescale 1ns/10ps

module dc_ddr_mover #(
    parameter logic [dc_pkg::DDR_ADDR_W-1:0] DDR_BASE = 28'h100_0000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  logic                       write_back,
    input  logic [dc_pkg::TAG_W-1:0]   tag,
    input  logic                       ddr_rd_empty,
    input  logic [dc_pkg::WORD_W-1:0]  ddr_rd_data,
    input  logic [dc_pkg::WORD_W-1:0]  arr_rdata,
    output logic                       done,
    output logic [dc_pkg::ROW_W-1:0]   arr_idx,
    output logic                       arr_we,
    output logic [dc_pkg::WORD_W-1:0]  arr_wdata,
    output logic                       ddr_req_valid,
    output dc_pkg::ddr_req_t           ddr_req,
    output logic                       ddr_wr_valid,
    output dc_pkg::ddr_wr_t            ddr_wr,
    output logic                       ddr_rd_en
);

    localparam int PAD_W = dc_pkg::DDR_ADDR_W - dc_pkg::TAG_W - dc_pkg::ROW_W;

    typedef enum logic [1:0] {
        M_IDLE,
        M_REQ,
        M_WB,
        M_FILL
    } mv_state_t;

    mv_state_t mstate;
    logic [dc_pkg::ROW_W-1:0] cnt;
    logic wb_q;
    logic [dc_pkg::DDR_ADDR_W-1:0] base_q;
    logic last;

    assign last = (cnt == dc_pkg::ROW_W'(dc_pkg::ROWS - 1));

    assign ddr_req_valid = (mstate == M_REQ);
    assign ddr_req.write = wb_q;
    assign ddr_req.addr  = base_q;

    // write-back streams the row under cnt straight out
    assign ddr_wr_valid = (mstate == M_WB);
    assign ddr_wr.idx   = cnt;
    assign ddr_wr.data  = arr_rdata;

    assign ddr_rd_en = (mstate == M_FILL) && !ddr_rd_empty;
    assign arr_idx   = cnt;
    assign arr_we    = ddr_rd_en;
    assign arr_wdata = ddr_rd_data;

    assign done = ((mstate == M_WB) || ddr_rd_en) && last;

    always_ff @(posedge clk) begin
        if (start) base_q <= DDR_BASE + {{PAD_W{1'b0}}, tag, {dc_pkg::ROW_W{1'b0}}};
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mstate <= M_IDLE;
            cnt    <= '0;
            wb_q   <= 1'b0;
        end else if (start) begin  // may arrive in the cycle of done
            mstate <= M_REQ;
            cnt    <= '0;
            wb_q   <= write_back;
        end else begin
            case (mstate)
                M_REQ: mstate <= wb_q ? M_WB : M_FILL;
                M_WB: begin
                    cnt <= cnt + 1'b1;
                    if (last) mstate <= M_IDLE;
                end
                M_FILL: begin
                    if (ddr_rd_en) begin
                        cnt <= cnt + 1'b1;
                        if (last) mstate <= M_IDLE;
                    end
                end
                default: mstate <= M_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/dc_ctrl.sv
`timescale 1ns/10ps

module dc_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  dc_pkg::dc_cmd_t            head,
    input  logic                       head_valid,
    input  logic                       mv_done,
    input  logic [dc_pkg::WORD_W-1:0]  row_rdata,
    input  logic [dc_pkg::ROWS-1:0]    col_rdata,
    input  logic                       rsp_space,
    output logic                       pop,
    output logic                       mv_start,
    output logic                       mv_write_back,
    output logic [dc_pkg::TAG_W-1:0]   mv_tag,
    output logic                       mv_active,
    output logic                       row_we,
    output logic [dc_pkg::ROW_W-1:0]   row_idx,
    output logic [dc_pkg::WORD_W-1:0]  row_wdata,
    output logic                       col_we,
    output logic [dc_pkg::ROW_W-1:0]   col_idx,
    output logic [dc_pkg::ROWS-1:0]    col_wdata,
    output logic                       rsp_issue,
    output dc_pkg::dc_rsp_t            rsp_data
);

    dc_pkg::dc_state_t state;
    dc_pkg::dc_cmd_t cmd_q;
    dc_pkg::dc_rsp_t rsp_q;
    dc_pkg::dc_rsp_t acc_rsp;
    logic [dc_pkg::TAG_W-1:0] tag_q;
    logic [dc_pkg::TAG_W-1:0] cmd_tag;
    logic valid_q;
    logic dirty_q;
    logic hit_q;
    logic is_flush;
    logic is_write;
    logic tag_hit;
    logic need_wb;

    assign cmd_tag  = cmd_q.addr[dc_pkg::ADDR_W-1:dc_pkg::ROW_W];
    assign is_flush = (cmd_q.op == dc_pkg::OP_FLUSH);
    assign is_write = (cmd_q.op == dc_pkg::OP_ROW_WRITE) || (cmd_q.op == dc_pkg::OP_COL_WRITE);
    assign tag_hit  = valid_q && (tag_q == cmd_tag);
    assign need_wb  = valid_q && dirty_q;

    assign pop = (state == dc_pkg::S_IDLE) && head_valid;

    // fill follows the write-back in the cycle of mv_done
    assign mv_start = ((state == dc_pkg::S_CHECK) && (is_flush ? need_wb : !tag_hit))
                   || ((state == dc_pkg::S_WRITEBACK) && mv_done && !is_flush);
    assign mv_write_back = (state == dc_pkg::S_CHECK) && need_wb;
    assign mv_tag        = mv_write_back ? tag_q : cmd_tag;
    assign mv_active     = (state == dc_pkg::S_WRITEBACK) || (state == dc_pkg::S_FILL);

    assign row_we    = (state == dc_pkg::S_ACCESS) && (cmd_q.op == dc_pkg::OP_ROW_WRITE);
    assign row_idx   = cmd_q.addr[dc_pkg::ROW_W-1:0];
    assign row_wdata = cmd_q.wdata;
    assign col_we    = (state == dc_pkg::S_ACCESS) && (cmd_q.op == dc_pkg::OP_COL_WRITE);
    assign col_idx   = cmd_q.col;
    assign col_wdata = cmd_q.wdata;

    assign rsp_issue = (state == dc_pkg::S_RESPOND) && rsp_space;
    assign rsp_data  = rsp_q;

    always_comb begin
        acc_rsp.op  = cmd_q.op;
        acc_rsp.hit = hit_q;
        case (cmd_q.op)
            dc_pkg::OP_ROW_READ: acc_rsp.rdata = row_rdata;
            dc_pkg::OP_COL_READ: acc_rsp.rdata = col_rdata;
            default:             acc_rsp.rdata = '0;  // writes and flush
        endcase
    end

    always_ff @(posedge clk) begin
        if (pop) cmd_q <= head;
        if (state == dc_pkg::S_CHECK) hit_q <= is_flush || tag_hit;
        if ((state == dc_pkg::S_FILL) && mv_done) tag_q <= cmd_tag;
        if (state == dc_pkg::S_ACCESS) rsp_q <= acc_rsp;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state   <= dc_pkg::S_IDLE;
            valid_q <= 1'b0;
            dirty_q <= 1'b0;
        end else begin
            case (state)
                dc_pkg::S_IDLE: if (head_valid) state <= dc_pkg::S_CHECK;
                dc_pkg::S_CHECK: begin
                    if (is_flush || tag_hit) begin
                        state <= (is_flush && need_wb) ? dc_pkg::S_WRITEBACK : dc_pkg::S_ACCESS;
                    end else begin
                        state <= need_wb ? dc_pkg::S_WRITEBACK : dc_pkg::S_FILL;
                    end
                end
                dc_pkg::S_WRITEBACK: begin
                    if (mv_done) begin
                        dirty_q <= 1'b0;
                        state   <= is_flush ? dc_pkg::S_ACCESS : dc_pkg::S_FILL;
                    end
                end
                dc_pkg::S_FILL: begin
                    if (mv_done) begin
                        valid_q <= 1'b1;
                        state   <= dc_pkg::S_ACCESS;
                    end
                end
                dc_pkg::S_ACCESS: begin
                    if (is_write) dirty_q <= 1'b1;
                    state <= dc_pkg::S_RESPOND;
                end
                dc_pkg::S_RESPOND: if (rsp_space) state <= dc_pkg::S_IDLE;
                default: state <= dc_pkg::S_IDLE;
            endcase
        end
    end

endmodule

// File: rtl/dc_rsp_out.sv
`timescale 1ns/10ps

module dc_rsp_out #(
    parameter int RSP_CREDITS = 2
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            rsp_issue,
    input  dc_pkg::dc_rsp_t rsp_data,
    input  logic            rsp_credit,
    output logic            rsp_space,
    output logic            rsp_valid,
    output dc_pkg::dc_rsp_t rsp
);

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);

    logic [CNT_W-1:0] credits;

    assign rsp_space = (credits != '0);

    always_ff @(posedge clk) begin
        if (rsp_issue) rsp <= rsp_data;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            credits   <= CNT_W'(RSP_CREDITS);
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= rsp_issue;
            // issue and a returned credit in one cycle cancel out
            case ({rsp_issue, rsp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

endmodule

// File: rtl/dc_top.sv
`timescale 1ns/10ps

module dc_top #(
    parameter int CMD_DEPTH   = 4,
    parameter int RSP_CREDITS = 2,
    parameter logic [dc_pkg::DDR_ADDR_W-1:0] DDR_BASE = 28'h100_0000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  dc_pkg::dc_cmd_t            cmd,
    input  logic                       rsp_credit,
    input  logic                       ddr_rd_empty,
    input  logic [dc_pkg::WORD_W-1:0]  ddr_rd_data,
    output logic                       cmd_credit,
    output logic                       rsp_valid,
    output dc_pkg::dc_rsp_t            rsp,
    output logic                       ddr_req_valid,
    output dc_pkg::ddr_req_t           ddr_req,
    output logic                       ddr_wr_valid,
    output dc_pkg::ddr_wr_t            ddr_wr,
    output logic                       ddr_rd_en
);

    dc_pkg::dc_cmd_t head;
    dc_pkg::dc_rsp_t rsp_data;
    logic head_valid;
    logic pop;
    logic rsp_issue;
    logic rsp_space;
    logic mv_start;
    logic mv_write_back;
    logic mv_done;
    logic mv_active;
    logic [dc_pkg::TAG_W-1:0] mv_tag;
    logic [dc_pkg::ROW_W-1:0] mv_idx;
    logic mv_we;
    logic [dc_pkg::WORD_W-1:0] mv_wdata;
    logic c_row_we;
    logic [dc_pkg::ROW_W-1:0] c_row_idx;
    logic [dc_pkg::WORD_W-1:0] c_row_wdata;
    logic col_we;
    logic [dc_pkg::ROW_W-1:0] col_idx;
    logic [dc_pkg::ROWS-1:0] col_wdata;
    logic [dc_pkg::ROWS-1:0] col_rdata;
    logic row_we;
    logic [dc_pkg::ROW_W-1:0] row_idx;
    logic [dc_pkg::WORD_W-1:0] row_wdata;
    logic [dc_pkg::WORD_W-1:0] row_rdata;

    // mover owns the row port during write-back and fill
    assign row_we    = mv_active ? mv_we    : c_row_we;
    assign row_idx   = mv_active ? mv_idx   : c_row_idx;
    assign row_wdata = mv_active ? mv_wdata : c_row_wdata;

    dc_cmd_queue #(.CMD_DEPTH(CMD_DEPTH)) u_cmd_queue (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .pop(pop),
        .cmd_credit(cmd_credit), .head(head), .head_valid(head_valid)
    );

    dc_ctrl u_ctrl (
        .clk(clk), .rst(rst), .head(head), .head_valid(head_valid),
        .mv_done(mv_done), .row_rdata(row_rdata), .col_rdata(col_rdata),
        .rsp_space(rsp_space), .pop(pop), .mv_start(mv_start),
        .mv_write_back(mv_write_back), .mv_tag(mv_tag), .mv_active(mv_active),
        .row_we(c_row_we), .row_idx(c_row_idx), .row_wdata(c_row_wdata),
        .col_we(col_we), .col_idx(col_idx), .col_wdata(col_wdata),
        .rsp_issue(rsp_issue), .rsp_data(rsp_data)
    );

    dc_block_array u_block_array (
        .clk(clk), .row_we(row_we), .row_idx(row_idx), .row_wdata(row_wdata),
        .col_we(col_we), .col_idx(col_idx), .col_wdata(col_wdata),
        .row_rdata(row_rdata), .col_rdata(col_rdata)
    );

    dc_ddr_mover #(.DDR_BASE(DDR_BASE)) u_ddr_mover (
        .clk(clk), .rst(rst), .start(mv_start), .write_back(mv_write_back),
        .tag(mv_tag), .ddr_rd_empty(ddr_rd_empty), .ddr_rd_data(ddr_rd_data),
        .arr_rdata(row_rdata), .done(mv_done), .arr_idx(mv_idx), .arr_we(mv_we),
        .arr_wdata(mv_wdata), .ddr_req_valid(ddr_req_valid), .ddr_req(ddr_req),
        .ddr_wr_valid(ddr_wr_valid), .ddr_wr(ddr_wr), .ddr_rd_en(ddr_rd_en)
    );

    dc_rsp_out #(.RSP_CREDITS(RSP_CREDITS)) u_rsp_out (
        .clk(clk), .rst(rst), .rsp_issue(rsp_issue), .rsp_data(rsp_data),
        .rsp_credit(rsp_credit), .rsp_space(rsp_space), .rsp_valid(rsp_valid),
        .rsp(rsp)
    );

endmodule

// File: testbench/tb_dc.sv
`timescale 1ns/10ps

module tb_dc;

    localparam int CMD_DEPTH    = 4;
    localparam int RSP_CREDITS  = 2;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CMDS     = 64;
    localparam int CYCLES_PER_CMD = 60;
    localparam logic [dc_pkg::DDR_ADDR_W-1:0] DDR_BASE = 28'h100_0000;

    logic clk;
    logic rst;
    logic cmd_valid;
    dc_pkg::dc_cmd_t cmd;
    logic rsp_credit;
    logic ddr_rd_empty;
    logic [dc_pkg::WORD_W-1:0] ddr_rd_data;
    logic cmd_credit;
    logic rsp_valid;
    dc_pkg::dc_rsp_t rsp;
    logic ddr_req_valid;
    dc_pkg::ddr_req_t ddr_req;
    logic ddr_wr_valid;
    dc_pkg::ddr_wr_t ddr_wr;
    logic ddr_rd_en;

    logic [15:0] stim [6*MAX_CMDS];    // six fields per command
    logic [15:0] ddr_mem [int unsigned];
    logic [15:0] rd_fifo [$];
    int unsigned due_q [$];            // cycles at which rsp_credit goes back
    int seed;
    int n_cmds;
    int sent;
    int rsp_idx;
    int credits;
    int spent;
    int returned;
    int wr_left;
    int rd_wait;
    int unsigned cycles = 0;
    int unsigned limit = 32'hFFFF_FFFF;
    int unsigned last_due;
    logic dirty_exp;
    logic [dc_pkg::TAG_W-1:0] resident_tag;
    logic [dc_pkg::DDR_ADDR_W-1:0] wr_base;

    dc_top #(
        .CMD_DEPTH(CMD_DEPTH),
        .RSP_CREDITS(RSP_CREDITS),
        .DDR_BASE(DDR_BASE)
    ) uut (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd(cmd), .rsp_credit(rsp_credit),
        .ddr_rd_empty(ddr_rd_empty), .ddr_rd_data(ddr_rd_data), .cmd_credit(cmd_credit),
        .rsp_valid(rsp_valid), .rsp(rsp), .ddr_req_valid(ddr_req_valid), .ddr_req(ddr_req),
        .ddr_wr_valid(ddr_wr_valid), .ddr_wr(ddr_wr), .ddr_rd_en(ddr_rd_en)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic fail_with(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    function automatic logic [15:0] ddr_word(input logic [dc_pkg::DDR_ADDR_W-1:0] a);
        if (ddr_mem.exists(a)) return ddr_mem[a];
        return a[15:0] ^ 16'h3C5A;  // contents before any write-back
    endfunction

    function automatic logic [dc_pkg::DDR_ADDR_W-1:0] block_base(
        input logic [dc_pkg::TAG_W-1:0] tag
    );
        return DDR_BASE + 28'(tag) * 28'd16;
    endfunction

    task automatic drive_inputs();
        cmd_valid = 1'b0;
        if (sent < n_cmds && credits > 0) begin
            cmd_valid = 1'b1;
            cmd.op    = dc_pkg::dc_op_t'(stim[6*sent][2:0]);
            cmd.addr  = stim[6*sent+1];
            cmd.col   = stim[6*sent+2][3:0];
            cmd.wdata = stim[6*sent+3];
            sent++;
            credits--;
            spent++;
        end
        rsp_credit = 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycles) begin
            rsp_credit = 1'b1;
            void'(due_q.pop_front());
        end
        if (rd_wait > 0) begin
            rd_wait--;
            ddr_rd_empty = 1'b1;
        end else if (rd_fifo.size() > 0 && ($unsigned($random(seed)) % 4) == 0) begin
            ddr_rd_empty = 1'b1;  // occasional gap in the read stream
        end else begin
            ddr_rd_empty = (rd_fifo.size() == 0);
        end
        ddr_rd_data = (rd_fifo.size() > 0) ? rd_fifo[0] : 16'h0;
    endtask

    task automatic sample_outputs();
        int cur;
        int unsigned due;
        if (cmd_credit) begin
            credits++;
            returned++;
            if (returned > spent) fail_with("cmd_credit returned more credits than were spent");
        end
        if (rsp_valid) begin
            if (rsp_idx >= n_cmds) fail_with("a response arrived with no command left");
            cur = 6 * rsp_idx;
            check($sformatf("cmd %0d op", rsp_idx), 32'(stim[cur]), 32'(rsp.op));
            check($sformatf("cmd %0d hit", rsp_idx), 32'(stim[cur+5]), 32'(rsp.hit));
            check($sformatf("cmd %0d rdata", rsp_idx), 32'(stim[cur+4]), 32'(rsp.rdata));
            if (dirty_exp && (!stim[cur+5][0] || stim[cur] == 16'd4)) begin
                fail_with("a dirty block was dropped without a write-back");
            end
            if (stim[cur] == 16'd1 || stim[cur] == 16'd3) dirty_exp = 1'b1;
            if (!stim[cur+5][0]) resident_tag = stim[cur+1][15:4];  // miss brings in a new block
            due = cycles + 1 + ($unsigned($random(seed)) % 8);
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            due_q.push_back(due);
            rsp_idx++;
        end
        if (ddr_req_valid) begin
            if (rsp_idx >= n_cmds) fail_with("a DDR request arrived with no command left");
            cur = 6 * rsp_idx;
            if (ddr_req.write) begin
                if (!dirty_exp) fail_with("write-back of a clean block");
                if (stim[cur+5][0] && stim[cur] != 16'd4) fail_with("write-back on a hit");
                check("write-back base", 32'(block_base(resident_tag)), 32'(ddr_req.addr));
                dirty_exp = 1'b0;
                wr_left   = 16;
                wr_base   = ddr_req.addr;
            end else begin
                if (stim[cur+5][0]) fail_with("fill request on a hit or a flush");
                check("fill base", 32'(block_base(stim[cur+1][15:4])), 32'(ddr_req.addr));
                for (int i = 0; i < 16; i++) begin
                    rd_fifo.push_back(ddr_word(ddr_req.addr + 28'(i)));
                end
                rd_wait = 1 + int'($unsigned($random(seed)) % 8);
            end
        end
        if (ddr_wr_valid) begin
            if (wr_left == 0) fail_with("ddr_wr_valid outside a write-back burst");
            check("write-back index", 32'(16 - wr_left), 32'(ddr_wr.idx));
            ddr_mem[wr_base + 28'(ddr_wr.idx)] = ddr_wr.data;
            wr_left--;
        end
        if (ddr_rd_en) begin
            if (ddr_rd_empty) fail_with("ddr_rd_en while the read FIFO is empty");
            void'(rd_fifo.pop_front());
        end
    endtask

    // inputs change at the falling edge, outputs are read 1 ns later
    task automatic run_cycle();
        @(negedge clk);
        drive_inputs();
        #1;
        sample_outputs();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        cmd_valid = 1'b0;
        cmd = '0;
        rsp_credit = 1'b0;
        ddr_rd_empty = 1'b1;
        ddr_rd_data = '0;
        seed = 37160;
        sent = 0;
        rsp_idx = 0;
        credits = CMD_DEPTH;
        spent = 0;
        returned = 0;
        wr_left = 0;
        rd_wait = 0;
        last_due = 0;
        dirty_exp = 1'b0;
        resident_tag = '0;
        wr_base = '0;
        for (int i = 0; i < 6*MAX_CMDS; i++) stim[i] = 16'hFFFF;
        $readmemh("testbench/dc_stim.txt", stim);
        n_cmds = 0;
        while (n_cmds < MAX_CMDS && stim[6*n_cmds] != 16'hFFFF) n_cmds++;
        if (n_cmds == 0) fail_with("no commands found in the stimulus file");
        limit = n_cmds * CYCLES_PER_CMD + RESET_CYCLES;

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        #1;
        check("reset outputs", 32'd0,
              {27'd0, cmd_credit, rsp_valid, ddr_req_valid, ddr_wr_valid, ddr_rd_en});

        while (rsp_idx < n_cmds) run_cycle();
        repeat (20) run_cycle();  // quiet tail catches stray transfers

        if (credits == CMD_DEPTH && wr_left == 0 && rd_fifo.size() == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            fail_with("run ended with command credits missing or a DDR transfer open");
        end
    end

endmodule

// File: testbench/dc_stim.txt
// op addr col wdata exp_rdata exp_hit, all hex
// op 0 row read, 1 row write, 2 col read, 3 col write, 4 flush
0 0123 0 0000 3d79 0
0 012f 0 0000 3d75 1
1 0121 0 a5c3 0000 1
0 0121 0 0000 a5c3 1
1 0124 0 0000 0000 1
2 0120 d 0000 ffef 1
3 0120 4 0012 0000 1
0 0120 0 0000 3d6a 1
0 0121 0 0000 a5d3 1
2 0120 4 0000 0012 1
0 0456 0 0000 380c 0
1 0457 0 1234 0000 1
4 0000 0 0000 0000 1
4 0000 0 0000 0000 1
0 0121 0 0000 a5d3 0
0 0124 0 0000 0010 1
1 0ff0 0 beef 0000 0
0 0457 0 0000 1234 0
0 0ff0 0 0000 beef 0
3 0ff0 f ffff 0000 1
0 0ff3 0 0000 b3a9 1
4 0000 0 0000 0000 1

// File: verilog.f
rtl/dc_pkg.sv
rtl/dc_cmd_queue.sv
rtl/dc_block_array.sv
rtl/dc_ddr_mover.sv
rtl/dc_ctrl.sv
rtl/dc_rsp_out.sv
rtl/dc_top.sv
testbench/tb_dc.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_dc -o Vtb_dc

# the exit status comes from the search for the pass line
./obj_dir/Vtb_dc | tee /dev/stderr | grep -x "Test passed" > /dev/null
